// ==== verilog/cpuPkg.sv ====
// Shared constants for the execution core: word widths, MIPS opcode and
// function code values, and the ALU operation enumeration.
package cpuPkg;
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 1 << regAddrWidth;
	localparam int immWidth = 16;

	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLui = 6'b001111;

	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnMovz = 6'b001010;
	localparam logic [5:0] fnMovn = 6'b001011;
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSra, aluSrl, aluAnd, aluOr,
		aluXor, aluNor, aluSlt, aluSltu, aluMovn, aluMovz, aluLui
	} aluOpT;
endpackage

// ==== verilog/ctrlIf.sv ====
// Decoded control bundle passed from the decoder to the ALU and write-back.
interface ctrlIf;
	logic valid;
	cpuPkg::aluOpT aluOp;
	logic useImm;
	logic signExt; // zero extension when low.
	logic useShamt;
	logic [cpuPkg::regAddrWidth-1:0] shamt;
	logic [cpuPkg::immWidth-1:0] imm;
	logic [cpuPkg::regAddrWidth-1:0] rs;
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::regAddrWidth-1:0] dest;
	logic regWrite;

	modport ctrl (
		output valid, aluOp, useImm, signExt, useShamt, shamt, imm, rs, rt, dest, regWrite
	);
	modport exec (
		input valid, aluOp, useImm, signExt, useShamt, shamt, imm, regWrite
	);
	modport wb (
		input valid, rs, rt, dest
	);
endinterface

// ==== verilog/instrFetch.sv ====
// Input register stage holding the incoming instruction word and its strobe.
module instrFetch (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [cpuPkg::dataWidth-1:0] instr,
	output logic fetchValid,
	output logic [cpuPkg::dataWidth-1:0] fetchInstr
);

	always_ff @(posedge clk or negedge rstN)
		begin
			if (!rstN)
				fetchValid <= 1'b0;
			else
				fetchValid <= instrValid;
		end

	// the word only moves when a new instruction arrives.
	always_ff @(posedge clk)
		begin
			if (instrValid)
				fetchInstr <= instr;
		end

endmodule

// ==== verilog/decoder.sv ====
// Control unit: opcode and function code decode into the control bundle,
// with an illegal flag for anything outside the supported set.
module decoder (
	input logic fetchValid,
	input logic [cpuPkg::dataWidth-1:0] fetchInstr,
	ctrlIf.ctrl bus,
	output logic illegal
);
	logic [5:0] opCode;
	logic [5:0] funcCode;
	logic [cpuPkg::regAddrWidth-1:0] rd;

	assign opCode = fetchInstr[31:26];
	assign funcCode = fetchInstr[5:0];
	assign rd = fetchInstr[15:11];

	assign bus.valid = fetchValid;
	assign bus.rs = fetchInstr[25:21];
	assign bus.rt = fetchInstr[20:16];
	assign bus.shamt = fetchInstr[10:6];
	assign bus.imm = fetchInstr[15:0];

	always_comb
		begin
			bus.aluOp = cpuPkg::aluAdd;
			bus.useImm = 1'b0;
			bus.signExt = 1'b0;
			bus.useShamt = 1'b0;
			bus.dest = bus.rt; // I-type target.
			bus.regWrite = 1'b0;
			illegal = 1'b0;

			case (opCode)
				cpuPkg::opSpecial:
					begin
						bus.dest = rd;
						bus.regWrite = 1'b1;
						case (funcCode)
							cpuPkg::fnAdd, cpuPkg::fnAddu: bus.aluOp = cpuPkg::aluAdd;
							cpuPkg::fnSub, cpuPkg::fnSubu: bus.aluOp = cpuPkg::aluSub;
							cpuPkg::fnSllv: bus.aluOp = cpuPkg::aluSll;
							cpuPkg::fnSrav: bus.aluOp = cpuPkg::aluSra;
							cpuPkg::fnSrlv: bus.aluOp = cpuPkg::aluSrl;
							cpuPkg::fnAnd: bus.aluOp = cpuPkg::aluAnd;
							cpuPkg::fnOr: bus.aluOp = cpuPkg::aluOr;
							cpuPkg::fnXor: bus.aluOp = cpuPkg::aluXor;
							cpuPkg::fnNor: bus.aluOp = cpuPkg::aluNor;
							cpuPkg::fnSlt: bus.aluOp = cpuPkg::aluSlt;
							cpuPkg::fnSltu: bus.aluOp = cpuPkg::aluSltu;
							cpuPkg::fnMovn: bus.aluOp = cpuPkg::aluMovn;
							cpuPkg::fnMovz: bus.aluOp = cpuPkg::aluMovz;
							cpuPkg::fnSll:
								begin
									bus.aluOp = cpuPkg::aluSll;
									bus.useShamt = 1'b1;
								end
							cpuPkg::fnSra:
								begin
									bus.aluOp = cpuPkg::aluSra;
									bus.useShamt = 1'b1;
								end
							cpuPkg::fnSrl:
								begin
									bus.aluOp = cpuPkg::aluSrl;
									bus.useShamt = 1'b1;
								end
							default:
								begin
									bus.regWrite = 1'b0; // multiply, HI/LO and jumps land here.
									illegal = fetchValid;
								end
						endcase
					end

				cpuPkg::opAddi, cpuPkg::opAddiu, cpuPkg::opSlti, cpuPkg::opSltiu:
					begin
						bus.useImm = 1'b1;
						bus.signExt = 1'b1;
						bus.regWrite = 1'b1;
						if (opCode == cpuPkg::opSlti)
							bus.aluOp = cpuPkg::aluSlt;
						else if (opCode == cpuPkg::opSltiu)
							bus.aluOp = cpuPkg::aluSltu; // sign extended, compared unsigned.
						else
							bus.aluOp = cpuPkg::aluAdd;
					end

				cpuPkg::opAndi, cpuPkg::opOri, cpuPkg::opXori, cpuPkg::opLui:
					begin
						bus.useImm = 1'b1;
						bus.regWrite = 1'b1;
						if (opCode == cpuPkg::opAndi)
							bus.aluOp = cpuPkg::aluAnd;
						else if (opCode == cpuPkg::opOri)
							bus.aluOp = cpuPkg::aluOr;
						else if (opCode == cpuPkg::opXori)
							bus.aluOp = cpuPkg::aluXor;
						else
							bus.aluOp = cpuPkg::aluLui;
					end

				default:
					illegal = fetchValid; // loads, stores and branches are not executed.
			endcase
		end

	always_comb
		begin
			knownInstr: assert final (!fetchValid || !$isunknown(fetchInstr))
				else $error("decoder received a valid instruction with unknown bits");
		end

endmodule

// ==== verilog/alu.sv ====
// Combinational ALU: operand selection, immediate extension, arithmetic,
// logic, shifts, compares and the conditional move write enable.
module alu (
	ctrlIf.exec bus,
	input logic [cpuPkg::dataWidth-1:0] rsData,
	input logic [cpuPkg::dataWidth-1:0] rtData,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic writeEnable
);
	logic [cpuPkg::dataWidth-1:0] extImm;
	logic [cpuPkg::dataWidth-1:0] opB;
	logic [cpuPkg::regAddrWidth-1:0] shiftAmt;

	assign extImm = bus.signExt
		? {{(cpuPkg::dataWidth - cpuPkg::immWidth){bus.imm[cpuPkg::immWidth-1]}}, bus.imm}
		: {{(cpuPkg::dataWidth - cpuPkg::immWidth){1'b0}}, bus.imm};
	assign opB = bus.useImm ? extImm : rtData;
	assign shiftAmt = bus.useShamt ? bus.shamt : rsData[cpuPkg::regAddrWidth-1:0];

	always_comb
		begin
			result = '0;
			case (bus.aluOp)
				cpuPkg::aluAdd: result = rsData + opB;
				cpuPkg::aluSub: result = rsData - opB;
				cpuPkg::aluSll: result = opB << shiftAmt;
				cpuPkg::aluSra: result = $signed(opB) >>> shiftAmt;
				cpuPkg::aluSrl: result = opB >> shiftAmt;
				cpuPkg::aluAnd: result = rsData & opB;
				cpuPkg::aluOr: result = rsData | opB;
				cpuPkg::aluXor: result = rsData ^ opB;
				cpuPkg::aluNor: result = ~(rsData | opB);
				cpuPkg::aluSlt: result[0] = $signed(rsData) < $signed(opB);
				cpuPkg::aluSltu: result[0] = rsData < opB;
				cpuPkg::aluLui:
					result = {bus.imm, {(cpuPkg::dataWidth - cpuPkg::immWidth){1'b0}}};
				default: result = rsData; // MOVN and MOVZ pass rs through.
			endcase
		end

	always_comb
		begin
			case (bus.aluOp)
				cpuPkg::aluMovn: writeEnable = bus.regWrite && (rtData != '0);
				cpuPkg::aluMovz: writeEnable = bus.regWrite && (rtData == '0);
				default: writeEnable = bus.regWrite;
			endcase
		end

	always_comb
		begin
			resultKnown: assert final (!bus.valid || !$isunknown(result))
				else $error("alu result has unknown bits for a valid instruction");
		end

endmodule

// ==== verilog/writeBack.sv ====
// Register file with asynchronous operand reads, result write and the
// registered write and illegal reports.
module writeBack (
	input logic clk,
	input logic rstN,
	ctrlIf.wb bus,
	input logic decodeIllegal,
	input logic [cpuPkg::dataWidth-1:0] result,
	input logic writeEnable,
	output logic [cpuPkg::dataWidth-1:0] rsData,
	output logic [cpuPkg::dataWidth-1:0] rtData,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic illegal
);
	logic [cpuPkg::dataWidth-1:0] regFile [cpuPkg::regCount];
	logic doWrite;

	assign rsData = (bus.rs == '0) ? '0 : regFile[bus.rs];
	assign rtData = (bus.rt == '0) ? '0 : regFile[bus.rt];
	assign doWrite = bus.valid && writeEnable && (bus.dest != '0); // register 0 is never written.

	always_ff @(posedge clk or negedge rstN)
		begin
			if (!rstN)
				begin
					for (int i = 0; i < cpuPkg::regCount; i++)
						regFile[i] <= '0;
					wbValid <= 1'b0;
					illegal <= 1'b0;
				end
			else
				begin
					wbValid <= doWrite;
					illegal <= decodeIllegal;
					if (doWrite)
						regFile[bus.dest] <= result;
				end
		end

	always_ff @(posedge clk)
		begin
			if (doWrite)
				begin
					wbReg <= bus.dest;
					wbData <= result;
				end
		end

	reportExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(wbValid && illegal))
		else $error("write report and illegal pulse issued together");

endmodule

// ==== verilog/execCore.sv ====
// Top level of the execution core: fetch register, decoder, ALU and
// write-back joined through the control bundle.
module execCore (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [31:0] instr,
	output logic wbValid,
	output logic [4:0] wbReg,
	output logic [31:0] wbData,
	output logic illegal
);
	logic fetchValid;
	logic [cpuPkg::dataWidth-1:0] fetchInstr;
	logic decodeIllegal;
	logic [cpuPkg::dataWidth-1:0] rsData;
	logic [cpuPkg::dataWidth-1:0] rtData;
	logic [cpuPkg::dataWidth-1:0] result;
	logic writeEnable;

	ctrlIf ctrlBus ();

	instrFetch fetch (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.fetchValid(fetchValid),
		.fetchInstr(fetchInstr)
	);

	decoder decode (
		.fetchValid(fetchValid),
		.fetchInstr(fetchInstr),
		.bus(ctrlBus),
		.illegal(decodeIllegal)
	);

	alu exec (
		.bus(ctrlBus),
		.rsData(rsData),
		.rtData(rtData),
		.result(result),
		.writeEnable(writeEnable)
	);

	writeBack wb (
		.clk(clk),
		.rstN(rstN),
		.bus(ctrlBus),
		.decodeIllegal(decodeIllegal),
		.result(result),
		.writeEnable(writeEnable),
		.rsData(rsData),
		.rtData(rtData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.illegal(illegal)
	);

endmodule

// ==== test/execCoreTb.sv ====
// Directed testbench for the execution core, with a reference register model
// and a queue of expected write and illegal reports.
module execCoreTb;
	logic clk = 1'b0;
	logic rstN;
	logic instrValid;
	logic [31:0] instr;
	logic wbValid;
	logic [4:0] wbReg;
	logic [31:0] wbData;
	logic illegal;

	logic [31:0] modelRegs [32];
	logic [37:0] expected [$]; // {illegal, register, value} per report.
	logic [31:0] seed = 32'd53784;
	int errors = 0;
	int checks = 0;

	execCore dut (.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .illegal(illegal));

	always #2 clk = ~clk;

	function logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] computeR(input logic [5:0] fn, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] sh);
		case (fn)
			cpuPkg::fnAdd, cpuPkg::fnAddu: return a + b;
			cpuPkg::fnSub, cpuPkg::fnSubu: return a - b;
			cpuPkg::fnSll: return b << sh;
			cpuPkg::fnSrl: return b >> sh;
			cpuPkg::fnSra: return $signed(b) >>> sh;
			cpuPkg::fnSllv: return b << a[4:0];
			cpuPkg::fnSrlv: return b >> a[4:0];
			cpuPkg::fnSrav: return $signed(b) >>> a[4:0];
			cpuPkg::fnAnd: return a & b;
			cpuPkg::fnOr: return a | b;
			cpuPkg::fnXor: return a ^ b;
			cpuPkg::fnNor: return ~(a | b);
			cpuPkg::fnSlt: return {31'b0, $signed(a) < $signed(b)};
			cpuPkg::fnSltu: return {31'b0, a < b};
			default: return a; // MOVN and MOVZ copy rs.
		endcase
	endfunction

	function automatic logic [31:0] computeI(input logic [5:0] op, input logic [31:0] a,
		input logic [15:0] imm);
		logic [31:0] sext;
		sext = {{16{imm[15]}}, imm};
		case (op)
			cpuPkg::opSlti: return {31'b0, $signed(a) < $signed(sext)};
			cpuPkg::opSltiu: return {31'b0, a < sext};
			cpuPkg::opAndi: return a & {16'b0, imm};
			cpuPkg::opOri: return a | {16'b0, imm};
			cpuPkg::opXori: return a ^ {16'b0, imm};
			cpuPkg::opLui: return {imm, 16'b0};
			default: return a + sext; // ADDI wraps like ADDIU.
		endcase
	endfunction

	task automatic sendInstr(input logic [31:0] word);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= word;
	endtask

	task automatic issueR(input logic [5:0] fn, input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh);
		logic [31:0] value;
		logic writes;
		value = computeR(fn, modelRegs[rs], modelRegs[rt], sh);
		writes = (rd != 5'd0);
		if (fn == cpuPkg::fnMovn)
			writes = writes && (modelRegs[rt] != 32'd0);
		if (fn == cpuPkg::fnMovz)
			writes = writes && (modelRegs[rt] == 32'd0);
		sendInstr({cpuPkg::opSpecial, rs, rt, rd, sh, fn});
		if (writes)
			begin
				modelRegs[rd] = value;
				expected.push_back({1'b0, rd, value});
			end
	endtask

	task automatic issueI(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
		input logic [15:0] imm);
		logic [31:0] value;
		value = computeI(op, modelRegs[rs], imm);
		sendInstr({op, rs, rt, imm});
		if (rt != 5'd0)
			begin
				modelRegs[rt] = value;
				expected.push_back({1'b0, rt, value});
			end
	endtask

	task automatic issueIllegal(input logic [31:0] word);
		sendInstr(word);
		expected.push_back({1'b1, 5'd0, 32'd0});
	endtask

	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		issueI(cpuPkg::opLui, 5'd0, rd, value[31:16]);
		issueI(cpuPkg::opOri, rd, rd, value[15:0]);
	endtask

	// the flush count covers the fixed two-cycle latency of the last instruction.
	task automatic waitIdle();
		int cycles;
		@(posedge clk);
		instrValid <= 1'b0;
		cycles = 0;
		while ((expected.size() != 0 || cycles < 3) && cycles < 100)
			begin
				@(posedge clk);
				cycles++;
			end
		if (expected.size() != 0)
			begin
				errors++;
				$display("timeout at %0t: %0d expected reports never arrived", $time,
					expected.size());
				expected.delete();
			end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
	endtask

	task automatic checkReport();
		logic [37:0] entry;
		checks++;
		if (expected.size() == 0)
			begin
				errors++;
				$display("unexpected report at %0t: wbValid %b illegal %b with nothing pending",
					$time, wbValid, illegal);
			end
		else
			begin
				entry = expected.pop_front();
				if (illegal !== entry[37])
					reportMismatch("illegal", {31'b0, entry[37]}, {31'b0, illegal});
				if (wbValid !== !entry[37])
					reportMismatch("wbValid", {31'b0, !entry[37]}, {31'b0, wbValid});
				if (wbValid === 1'b1 && wbReg !== entry[36:32])
					reportMismatch("wbReg", {27'b0, entry[36:32]}, {27'b0, wbReg});
				if (wbValid === 1'b1 && wbData !== entry[31:0])
					reportMismatch("wbData", entry[31:0], wbData);
			end
	endtask

	// outputs change on the rising edge, so reports are sampled half a cycle later.
	always @(negedge clk)
		begin
			if (rstN === 1'b1 && (wbValid === 1'b1 || illegal === 1'b1))
				checkReport();
		end

	task automatic testImmediates();
		logic [31:0] consts [8];
		consts = '{32'h12345678, 32'hffff0000, 32'h0000ffff, 32'h80000000,
			32'h7fffffff, 32'hdeadbeef, 32'h00000001, 32'hfffffffe};
		for (int i = 0; i < 8; i++)
			loadConst(5'(i + 1), consts[i]);
		waitIdle();
	endtask

	task automatic testRegOps();
		logic [5:0] fns [10];
		logic [31:0] a;
		logic [31:0] b;
		fns = '{cpuPkg::fnAdd, cpuPkg::fnAddu, cpuPkg::fnSub, cpuPkg::fnSubu, cpuPkg::fnAnd,
			cpuPkg::fnOr, cpuPkg::fnXor, cpuPkg::fnNor, cpuPkg::fnSlt, cpuPkg::fnSltu};
		for (int iter = 0; iter < 4; iter++)
			begin
				a = nextRand();
				b = nextRand();
				if (iter % 2 == 1)
					begin
						a[31] = 1'b1; // negative against positive splits SLT from SLTU.
						b[31] = 1'b0;
					end
				loadConst(5'd9, a);
				loadConst(5'd10, b);
				for (int i = 0; i < 10; i++)
					issueR(fns[i], (i == 0) ? 5'd9 : 5'(10 + i), 5'd10, 5'(11 + i), 5'd0);
				issueR(cpuPkg::fnSlt, 5'd9, 5'd10, 5'd21, 5'd0);
				issueR(cpuPkg::fnSltu, 5'd9, 5'd10, 5'd22, 5'd0);
				issueI(cpuPkg::opAddi, 5'd9, 5'd23, 16'hfffb);
				issueI(cpuPkg::opAddiu, 5'd23, 5'd24, a[15:0]);
				issueI(cpuPkg::opAndi, 5'd9, 5'd25, 16'h8f0f);
				issueI(cpuPkg::opXori, 5'd25, 5'd26, b[31:16]);
				issueI(cpuPkg::opSlti, 5'd9, 5'd27, 16'hff00);
				issueI(cpuPkg::opSltiu, 5'd9, 5'd28, 16'hff00);
			end
		waitIdle();
	endtask

	task automatic testShifts();
		logic [4:0] amounts [5];
		amounts = '{5'd0, 5'd1, 5'd4, 5'd13, 5'd31};
		loadConst(5'd1, 32'h80f01234);
		loadConst(5'd2, 32'h12345678);
		for (int i = 0; i < 5; i++)
			begin
				issueR(cpuPkg::fnSll, 5'd0, 5'd1, 5'd10, amounts[i]);
				issueR(cpuPkg::fnSrl, 5'd0, 5'd1, 5'd11, amounts[i]);
				issueR(cpuPkg::fnSra, 5'd0, 5'd1, 5'd12, amounts[i]);
				issueR(cpuPkg::fnSra, 5'd0, 5'd2, 5'd13, amounts[i]);
				loadConst(5'd4, {27'h2aaaaaa, amounts[i]}); // upper bits must be ignored.
				issueR(cpuPkg::fnSllv, 5'd4, 5'd1, 5'd14, 5'd0);
				issueR(cpuPkg::fnSrlv, 5'd4, 5'd1, 5'd15, 5'd0);
				issueR(cpuPkg::fnSrav, 5'd4, 5'd1, 5'd16, 5'd0);
				issueR(cpuPkg::fnSrav, 5'd4, 5'd2, 5'd17, 5'd0);
			end
		waitIdle();
	endtask

	task automatic testConditionalMoves();
		loadConst(5'd1, 32'hcafe0001);
		loadConst(5'd2, 32'd0);
		loadConst(5'd3, 32'd5);
		issueR(cpuPkg::fnMovn, 5'd1, 5'd3, 5'd5, 5'd0);
		issueR(cpuPkg::fnMovn, 5'd1, 5'd2, 5'd6, 5'd0);
		issueR(cpuPkg::fnMovz, 5'd1, 5'd2, 5'd7, 5'd0);
		issueR(cpuPkg::fnMovz, 5'd1, 5'd3, 5'd8, 5'd0);
		issueR(cpuPkg::fnOr, 5'd6, 5'd0, 5'd6, 5'd0); // or with $0 reports the old value.
		issueR(cpuPkg::fnOr, 5'd8, 5'd0, 5'd8, 5'd0);
		waitIdle();
	endtask

	task automatic testRegisterZero();
		issueI(cpuPkg::opOri, 5'd0, 5'd0, 16'h1234);
		issueR(cpuPkg::fnAddu, 5'd1, 5'd3, 5'd0, 5'd0);
		issueI(cpuPkg::opLui, 5'd0, 5'd0, 16'hbeef);
		issueR(cpuPkg::fnAddu, 5'd0, 5'd1, 5'd9, 5'd0);
		issueI(cpuPkg::opAddiu, 5'd0, 5'd10, 16'h0042);
		issueR(cpuPkg::fnNor, 5'd0, 5'd0, 5'd11, 5'd0);
		waitIdle();
	endtask

	task automatic testIllegal();
		issueIllegal({6'b100011, 5'd1, 5'd2, 16'h0010}); // LW
		issueIllegal({6'b000100, 5'd1, 5'd2, 16'h0004}); // BEQ
		issueIllegal({6'b000010, 26'h0000100}); // J
		issueIllegal({cpuPkg::opSpecial, 5'd1, 5'd2, 10'd0, 6'b011000}); // MULT
		waitIdle();
		for (int r = 1; r < 9; r++)
			issueR(cpuPkg::fnOr, 5'(r), 5'd0, 5'(r), 5'd0);
		waitIdle();
	endtask

	initial
		begin
			rstN = 1'b0;
			instrValid = 1'b0;
			instr = '0;
			for (int r = 0; r < 32; r++)
				modelRegs[r] = '0;
			repeat (2) @(posedge clk);
			rstN <= 1'b1;
			@(negedge clk);
			if (wbValid !== 1'b0 || illegal !== 1'b0)
				begin
					errors++;
					$display("outputs are not idle after reset at %0t", $time);
				end
			testImmediates();
			testRegOps();
			testShifts();
			testConditionalMoves();
			testRegisterZero();
			testIllegal();
			$display("reports checked %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
endmodule

// ==== sources.f ====
verilog/cpuPkg.sv
verilog/ctrlIf.sv
verilog/instrFetch.sv
verilog/decoder.sv
verilog/alu.sv
verilog/writeBack.sv
verilog/execCore.sv
test/execCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execution core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module execCoreTb \
	-f sources.f -o execCoreSim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/execCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
	exit 0
fi
exit 1
